/* common/vcore_config.svh */
`ifndef VCORE_CONFIG_SVH
`define VCORE_CONFIG_SVH

// instruction and scalar datapath
`define VCORE_INSTR_W 32
`define VCORE_INT_W 32

// base address width into the vector register file
`define VCORE_VRF_ADDR_W 12

// program memory depth is 2**VCORE_IMEM_AW words
`define VCORE_IMEM_AW 6

// commands in flight at the vector engine
`define VCORE_MAX_VEC_OUT 4

`endif

/* common/vcore_pkg.sv */
`include "vcore_config.svh"

package vcore_pkg;

    typedef logic [`VCORE_INSTR_W-1:0]    instr_t;
    typedef logic [`VCORE_INT_W-1:0]      word_t;
    typedef logic [`VCORE_VRF_ADDR_W-1:0] vrf_addr_t;

    typedef enum logic [2:0] {
        SC_LUI  = 3'b000,
        SC_ADDI = 3'b001,
        SC_BNE  = 3'b010,
        SC_ADD  = 3'b011,
        SC_CSR  = 3'b100,
        SC_NOP  = 3'b101
    } scalar_op_e;

    // command kinds sent to the vector engine
    typedef enum logic [2:0] {
        VC_LOAD   = 3'b000,
        VC_STORE  = 3'b001,
        VC_STREAM = 3'b010,
        VC_MACC   = 3'b011,
        VC_NOP    = 3'b100
    } vec_op_e;

endpackage

/* common/decode_if.sv */
`timescale 1ns/1ns

interface decode_if import vcore_pkg::*; ();

    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;

    scalar_op_e scalar_op;
    word_t      scalar_imm;   // I or U immediate
    logic [11:0] branch_imm;  // bne offset in halfwords
    logic       scalar_wen;

    vec_op_e   vec_op;
    vrf_addr_t vr_addr;
    vrf_addr_t vw_addr;
    logic      is_vect;
    logic      is_wfi;

    modport dec (
        output rs1, rs2, rd, scalar_op, scalar_imm, branch_imm, scalar_wen,
        output vec_op, vr_addr, vw_addr, is_vect, is_wfi
    );

    modport scal (
        input rs1, rs2, rd, scalar_op, scalar_imm, branch_imm, scalar_wen
    );

    // wfi is seen here so the drain wait can hold the core
    modport vec (
        input vec_op, vr_addr, vw_addr, is_vect, is_wfi
    );

endinterface

/* isa_decoder/isa_decoder.sv */
`timescale 1ns/1ns
`include "vcore_config.svh"

module isa_decoder import vcore_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  instr_t instr,
    input  logic   done_steady,
    decode_if.dec  dec,
    output logic   ap_done
);

    logic is_lui, is_addi, is_add, is_bne, is_csr;
    logic is_vle, is_vse, is_vmacc, is_vstream, is_vsetivli, is_wfi;
    logic [2:0] vlen;
    logic [4:0] vs2;
    logic [4:0] vd;
    logic done_flag;
    word_t i_imm;
    word_t u_imm;

    // register number lands at the top of the address
    function automatic vrf_addr_t scale_addr(input logic [4:0] vreg, input logic [2:0] len);
        logic [4:0] kept;
        for (int i = 0; i < 5; i++) begin
            kept[i] = vreg[i] & (i <= int'(len));
        end
        return vrf_addr_t'(kept) << (`VCORE_VRF_ADDR_W - 1 - int'(len));
    endfunction

    assign is_lui      = (instr[6:0] == 7'b0110111);
    assign is_addi     = (instr[6:0] == 7'b0010011) && (instr[14:12] == 3'b000);
    assign is_add      = (instr[6:0] == 7'b0110011) && (instr[14:12] == 3'b000)
                         && (instr[31:25] == 7'b0000000);
    assign is_bne      = (instr[6:0] == 7'b1100011) && (instr[14:12] == 3'b001);
    assign is_csr      = (instr[6:0] == 7'b0000011) && (instr[31:20] == 12'hc00); // cycle
    assign is_vle      = (instr[6:0] == 7'h07);
    assign is_vse      = (instr[6:0] == 7'h27);
    assign is_vmacc    = (instr[6:0] == 7'h57) && (instr[14:12] == 3'h0);
    assign is_vsetivli = (instr[6:0] == 7'h57) && (instr[14:12] == 3'h7);
    assign is_vstream  = (instr[6:0] == 7'h7f); // custom opcode
    assign is_wfi      = (instr == 32'h1050_0073);

    // scalar fields
    assign dec.rs1 = instr[19:15];
    assign dec.rs2 = instr[24:20];
    assign dec.rd  = instr[11:7];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign u_imm = {instr[31:12], 12'b0};

    assign dec.scalar_imm = is_addi ? i_imm : u_imm;
    assign dec.branch_imm = {instr[31], instr[7], instr[30:25], instr[11:8]};
    assign dec.scalar_wen = is_lui | is_addi | is_add | is_csr;

    always_comb begin
        if (is_lui) begin
            dec.scalar_op = SC_LUI;
        end else if (is_addi) begin
            dec.scalar_op = SC_ADDI;
        end else if (is_bne) begin
            dec.scalar_op = SC_BNE;
        end else if (is_add) begin
            dec.scalar_op = SC_ADD;
        end else if (is_csr) begin
            dec.scalar_op = SC_CSR;
        end else begin
            dec.scalar_op = SC_NOP;
        end
    end

    // vector length, set by vsetivli
    always_ff @(posedge clk) begin
        if (rst) begin
            vlen <= 3'd0;
        end else if (is_vsetivli) begin
            vlen <= instr[17:15];
        end
    end

    always_comb begin
        if (is_vle) begin
            dec.vec_op = VC_LOAD;
        end else if (is_vse) begin
            dec.vec_op = VC_STORE;
        end else if (is_vmacc) begin
            dec.vec_op = VC_MACC;
        end else if (is_vstream) begin
            dec.vec_op = VC_STREAM;
        end else begin
            dec.vec_op = VC_NOP;
        end
    end

    assign dec.is_vect = is_vle | is_vse | is_vmacc | is_vstream;
    assign dec.is_wfi  = is_wfi;

    assign vs2 = (is_vse | is_vstream) ? instr[11:7] : instr[24:20]; // store reads vd slot
    assign vd  = instr[11:7];

    assign dec.vr_addr = scale_addr(vs2, vlen);
    assign dec.vw_addr = scale_addr(vd, vlen);

    // one pulse per wfi until a non-wfi word shows up
    always_ff @(posedge clk) begin
        if (rst) begin
            done_flag <= 1'b0;
        end else if (ap_done) begin
            done_flag <= 1'b1;
        end else if (!is_wfi) begin
            done_flag <= 1'b0;
        end
    end

    assign ap_done = is_wfi & done_steady & ~done_flag;

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ns
`include "vcore_config.svh"

module fetch_unit import vcore_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     prog_we,
    input  logic [`VCORE_IMEM_AW-1:0] prog_addr,
    input  instr_t                   prog_data,
    input  logic                     stall,
    input  logic                     hold_wfi,
    input  logic                     branch_taken,
    input  word_t                    branch_target, // pc-relative byte offset
    output instr_t                   instr,
    output logic                     busy
);

    instr_t imem [2**`VCORE_IMEM_AW];
    word_t  pc;

    // loaded only while idle
    always_ff @(posedge clk) begin
        if (prog_we && !busy) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // idle core sees an all-zero word, which decodes to nothing
    assign instr = busy ? imem[pc[`VCORE_IMEM_AW+1:2]] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= '0;
            busy <= 1'b0;
        end else if (!busy) begin
            if (start) begin
                pc   <= '0;
                busy <= 1'b1;
            end
        end else begin
            // wfi without a stall means the engine has drained
            if (hold_wfi && !stall) begin
                busy <= 1'b0;
            end
            if (!stall && !hold_wfi) begin
                if (branch_taken) begin
                    pc <= pc + branch_target;
                end else begin
                    pc <= pc + 32'd4;
                end
            end
        end
    end

endmodule

/* logic/scalar_unit.sv */
`timescale 1ns/1ns

module scalar_unit import vcore_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       busy,
    input  logic       stall,
    decode_if.scal     dec,
    output logic       branch_taken,
    output word_t      branch_target,
    output logic       wb_valid,
    output logic [4:0] wb_rd,
    output word_t      wb_data
);

    word_t regs [32];
    word_t rs1_val;
    word_t rs2_val;
    word_t result;
    word_t cycle_cnt;
    logic  commit;

    assign rs1_val = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1]; // x0 reads zero
    assign rs2_val = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

    assign commit = busy & ~stall;

    always_comb begin
        case (dec.scalar_op)
            SC_LUI:  result = dec.scalar_imm;
            SC_ADDI: result = rs1_val + dec.scalar_imm;
            SC_ADD:  result = rs1_val + rs2_val;
            SC_CSR:  result = cycle_cnt;
            default: result = '0;
        endcase
    end

    assign wb_valid = commit & dec.scalar_wen;
    assign wb_rd    = dec.rd;
    assign wb_data  = result;

    always_ff @(posedge clk) begin
        if (wb_valid && dec.rd != 5'd0) begin
            regs[dec.rd] <= result;
        end
    end

    // bne
    assign branch_taken  = commit & (dec.scalar_op == SC_BNE) & (rs1_val != rs2_val);
    assign branch_target = {{19{dec.branch_imm[11]}}, dec.branch_imm, 1'b0};

    // cycles since start
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else if (!busy) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

endmodule

/* logic/vector_issue.sv */
`timescale 1ns/1ns
`include "vcore_config.svh"

module vector_issue import vcore_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    decode_if.vec     dec,
    input  logic      vec_done,
    output logic      stall,
    output logic      done_steady,
    output logic      vec_start,
    output vec_op_e   vec_op,
    output vrf_addr_t vec_src_addr,
    output vrf_addr_t vec_dst_addr
);

    localparam int CNT_W = $clog2(`VCORE_MAX_VEC_OUT + 1);

    logic [CNT_W-1:0] out_cnt; // commands in flight
    logic issue_ok;
    logic retire;

    always_comb begin
        case (dec.vec_op)
            VC_LOAD, VC_STORE:  issue_ok = (out_cnt == '0); // memory ops wait for a drain
            VC_MACC, VC_STREAM: issue_ok = (out_cnt < CNT_W'(`VCORE_MAX_VEC_OUT));
            default:            issue_ok = 1'b0;
        endcase
    end

    assign done_steady = (out_cnt == '0);
    assign retire      = vec_done & ~done_steady;
    assign stall       = (dec.is_vect & ~issue_ok) | (dec.is_wfi & ~done_steady);

    assign vec_start    = dec.is_vect & issue_ok;
    assign vec_op       = dec.vec_op;
    assign vec_src_addr = dec.vr_addr;
    assign vec_dst_addr = dec.vw_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_cnt <= '0;
        end else begin
            case ({vec_start, retire})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt; // none, or issue and retire together
            endcase
        end
    end

endmodule

/* logic/vcore_top.sv */
`timescale 1ns/1ns
`include "vcore_config.svh"

module vcore_top import vcore_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     prog_we,
    input  logic [`VCORE_IMEM_AW-1:0] prog_addr,
    input  instr_t                   prog_data,
    input  logic                     start,
    output logic                     vec_start,
    output vec_op_e                  vec_op,
    output vrf_addr_t                vec_src_addr,
    output vrf_addr_t                vec_dst_addr,
    input  logic                     vec_done,
    output logic                     wb_valid,
    output logic [4:0]               wb_rd,
    output word_t                    wb_data,
    output logic                     ap_done,
    output logic                     busy
);

    decode_if dec_bus ();

    instr_t instr;
    logic   stall;
    logic   done_steady;
    logic   branch_taken;
    word_t  branch_target;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .stall         (stall),
        .hold_wfi      (dec_bus.is_wfi),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .instr         (instr),
        .busy          (busy)
    );

    isa_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .done_steady (done_steady),
        .dec         (dec_bus.dec),
        .ap_done     (ap_done)
    );

    scalar_unit u_scalar (
        .clk           (clk),
        .rst           (rst),
        .busy          (busy),
        .stall         (stall),
        .dec           (dec_bus.scal),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    vector_issue u_vec_issue (
        .clk          (clk),
        .rst          (rst),
        .dec          (dec_bus.vec),
        .vec_done     (vec_done),
        .stall        (stall),
        .done_steady  (done_steady),
        .vec_start    (vec_start),
        .vec_op       (vec_op),
        .vec_src_addr (vec_src_addr),
        .vec_dst_addr (vec_dst_addr)
    );

endmodule

/* dv/vcore_checker.sv */
`timescale 1ns/1ns
`include "vcore_config.svh"

module vcore_checker import vcore_pkg::*; (
    input logic                      clk,
    input logic                      rst,
    input logic                      prog_we,
    input logic [`VCORE_IMEM_AW-1:0] prog_addr,
    input instr_t                    prog_data,
    input logic                      start,
    input logic                      vec_start,
    input vec_op_e                   vec_op,
    input vrf_addr_t                 vec_src_addr,
    input vrf_addr_t                 vec_dst_addr,
    input logic                      vec_done,
    input logic                      wb_valid,
    input logic [4:0]                wb_rd,
    input word_t                     wb_data,
    input logic                      ap_done,
    input logic                      busy
);

    localparam int STEP_LIMIT = 4096;
    localparam int I_OTHER = 0, I_LUI = 1, I_ADDI = 2, I_ADD = 3, I_CSR = 4, I_BNE = 5,
                   I_VSET = 6, I_VLE = 7, I_VSE = 8, I_VMACC = 9, I_VSTREAM = 10, I_WFI = 11;

    instr_t mem [2**`VCORE_IMEM_AW]; // program copy snooped from the load port
    word_t  mregs [32];
    word_t  pc;
    instr_t cur;                     // instruction the model stopped at
    int     vlen = 0;
    int     out_cnt = 0;
    int     cnt_before;
    int     run_cyc = 0;             // busy cycles since start
    int     err_cnt = 0;
    int     chk_cnt = 0;
    int     done_cnt = 0;
    logic   started = 1'b0;
    logic   finished = 1'b0;
    logic   csr_seen;
    word_t  last_csr;

    function automatic int classify(input instr_t w);
        if (w == 32'h1050_0073) return I_WFI;
        case (w[6:0])
            7'h37:   return I_LUI;
            7'h13:   return (w[14:12] == 3'd0) ? I_ADDI : I_OTHER;
            7'h33:   return (w[14:12] == 3'd0 && w[31:25] == 7'd0) ? I_ADD : I_OTHER;
            7'h63:   return (w[14:12] == 3'd1) ? I_BNE : I_OTHER;
            7'h03:   return (w[31:20] == 12'hc00) ? I_CSR : I_OTHER; // cycle counter read
            7'h07:   return I_VLE;
            7'h27:   return I_VSE;
            7'h57:   return (w[14:12] == 3'd0) ? I_VMACC : (w[14:12] == 3'd7) ? I_VSET : I_OTHER;
            7'h7f:   return I_VSTREAM;
            default: return I_OTHER;
        endcase
    endfunction

    function automatic word_t reg_val(input logic [4:0] r);
        return (r == 5'd0) ? '0 : mregs[r];
    endfunction

    // low len+1 register bits go to the top and lengths past 4 slide down by the excess
    function automatic vrf_addr_t expect_addr(input logic [4:0] vreg, input int len);
        int        nbits;
        int        excess;
        vrf_addr_t field;
        nbits  = (len + 1 > 5) ? 5 : len + 1;
        excess = (len > 4) ? len - 4 : 0;
        field  = vrf_addr_t'(vreg) & vrf_addr_t'((1 << nbits) - 1);
        return field << (`VCORE_VRF_ADDR_W - nbits - excess);
    endfunction

    task automatic report_problem(input string msg);
        err_cnt++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic compare(input string name, input word_t exp, input word_t got);
        chk_cnt++;
        if (exp !== got) begin
            err_cnt++;
            $display("FAILED %s: expected %h, got %h (pc %h)", name, exp, got, pc);
        end
    endtask

    // run silent instructions until the next one that shows at the ports
    task automatic step_model();
        int          steps;
        int          kind;
        logic [12:0] boff;
        steps = 0;
        cur   = mem[pc[`VCORE_IMEM_AW+1:2]];
        kind  = classify(cur);
        while ((kind == I_OTHER || kind == I_BNE || kind == I_VSET) && steps < STEP_LIMIT) begin
            if (kind == I_BNE && reg_val(cur[19:15]) != reg_val(cur[24:20])) begin
                boff = {cur[31], cur[7], cur[30:25], cur[11:8], 1'b0};
                pc   = pc + {{19{boff[12]}}, boff};
            end else begin
                if (kind == I_VSET) vlen = int'(cur[17:15]);
                pc = pc + 32'd4;
            end
            steps++;
            cur  = mem[pc[`VCORE_IMEM_AW+1:2]];
            kind = classify(cur);
        end
        if (steps >= STEP_LIMIT) report_problem("model found no visible instruction, runaway loop");
    endtask

    task automatic check_wb();
        word_t exp;
        step_model();
        case (classify(cur))
            I_LUI:  exp = {cur[31:12], 12'b0};
            I_ADDI: exp = reg_val(cur[19:15]) + {{20{cur[31]}}, cur[31:20]};
            I_ADD:  exp = reg_val(cur[19:15]) + reg_val(cur[24:20]);
            I_CSR: begin
                exp = word_t'(run_cyc);
                chk_cnt++;
                if (csr_seen && wb_data <= last_csr) report_problem("cycle csr did not increase");
                csr_seen = 1'b1;
                last_csr = wb_data;
            end
            default: begin
                report_problem("write-back where the program has no scalar write");
                return;
            end
        endcase
        compare("wb_rd", word_t'(cur[11:7]), word_t'(wb_rd));
        compare("wb_data", exp, wb_data);
        if (cur[11:7] != 5'd0) mregs[cur[11:7]] = exp;
        pc = pc + 32'd4;
    endtask

    task automatic check_vec();
        vec_op_e    exp_op;
        logic [4:0] src;
        step_model();
        src = cur[24:20];
        case (classify(cur))
            I_VLE:   exp_op = VC_LOAD;
            I_VMACC: exp_op = VC_MACC;
            I_VSE: begin
                exp_op = VC_STORE;
                src    = cur[11:7];   // store data comes from the rd slot
            end
            I_VSTREAM: begin
                exp_op = VC_STREAM;
                src    = cur[11:7];
            end
            default: begin
                report_problem("vector command where the program has none");
                return;
            end
        endcase
        compare("vec_op", word_t'(exp_op), word_t'(vec_op));
        compare("vec_src_addr", word_t'(expect_addr(src, vlen)), word_t'(vec_src_addr));
        compare("vec_dst_addr", word_t'(expect_addr(cur[11:7], vlen)), word_t'(vec_dst_addr));
        if ((exp_op == VC_LOAD || exp_op == VC_STORE) && cnt_before != 0)
            report_problem($sformatf("load or store issued with %0d outstanding", cnt_before));
        pc = pc + 32'd4;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            out_cnt  = 0;
            vlen     = 0;
            started  = 1'b0;
            finished = 1'b0;
            pc       = '0;
        end else begin
            if (prog_we && !busy) mem[prog_addr] = prog_data;
            if (!started && (vec_start || wb_valid || ap_done || busy))
                report_problem("control output high before the first start");
            if (start && !busy) begin
                started  = 1'b1;
                finished = 1'b0;
                csr_seen = 1'b0;
                run_cyc  = 0;
                pc       = '0;
            end
            if (finished && busy) report_problem("busy still high after ap_done");
            cnt_before = out_cnt;
            if (vec_done) out_cnt--;
            if (finished && (wb_valid || vec_start)) report_problem("activity after ap_done");
            if (wb_valid) check_wb();
            if (vec_start) begin
                check_vec();
                out_cnt++;
                if (out_cnt > `VCORE_MAX_VEC_OUT)
                    report_problem($sformatf("%0d vector commands outstanding", out_cnt));
            end
            if (ap_done) begin
                step_model();
                done_cnt++;
                if (classify(cur) != I_WFI) report_problem("ap_done before the program hit wfi");
                if (cnt_before != 0) report_problem("ap_done with vector commands in flight");
                if (finished) report_problem("second ap_done in one run");
                finished = 1'b1;
            end
            if (busy) run_cyc++;
        end
    end

endmodule

/* dv/vcore_tb.sv */
`timescale 1ns/1ns
`include "vcore_config.svh"

module vcore_tb import vcore_pkg::*; ();

    localparam int NUM_TESTS   = 6;
    localparam int MAX_WORDS   = 48;
    localparam int LOOP_FACTOR = 8;
    localparam int CYC_PER_INS = 8;
    localparam int TIMEOUT     = NUM_TESTS * MAX_WORDS * LOOP_FACTOR * CYC_PER_INS;
    localparam logic [31:0] SEED = 32'h6a66_1ef2;

    logic                      clk;
    logic                      rst;
    logic                      prog_we;
    logic [`VCORE_IMEM_AW-1:0] prog_addr;
    instr_t                    prog_data;
    logic                      start;
    logic                      vec_start;
    vec_op_e                   vec_op;
    vrf_addr_t                 vec_src_addr;
    vrf_addr_t                 vec_dst_addr;
    logic                      vec_done;
    logic                      wb_valid;
    logic [4:0]                wb_rd;
    word_t                     wb_data;
    logic                      ap_done;
    logic                      busy;

    logic [31:0] rng;
    int          cyc = 0;
    int          due_q [$];      // completion cycle of each command in flight
    instr_t      prog [MAX_WORDS];
    int          nwords;
    logic [31:0] written;        // registers holding a known value
    int          errs_before;

    vcore_top dut0 (.*);
    vcore_checker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rand_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic int pick(input int n);
        return int'((rand_next() >> 8) % n);
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_b(input logic [12:0] off, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [4:0] src_reg();
        int r;
        r = pick(32);
        return written[r] ? 5'(r) : 5'd0;
    endfunction

    task automatic put(input instr_t w);
        if (nwords < MAX_WORDS) begin
            prog[nwords] = w;
            nwords++;
        end
    endtask

    task automatic emit_scalar();
        logic [4:0]  rd;
        logic [31:0] r;
        int          kind;
        rd   = 5'(1 + pick(30)); // x31 stays the loop counter
        r    = rand_next();
        kind = pick(8);
        if (kind < 2) put({r[31:12], rd, 7'h37});
        else if (kind < 5) put(enc_i(r[11:0], src_reg(), 3'b000, rd, 7'h13));
        else if (kind < 7) put({7'd0, src_reg(), src_reg(), 3'b000, rd, 7'h33});
        else put(enc_i(12'hc00, 5'd0, 3'b010, rd, 7'h03)); // cycle csr
        written[rd] = 1'b1;
    endtask

    task automatic emit_mix();
        logic [31:0] r;
        int          k;
        r = rand_next();
        k = pick(10);
        if (k < 6) emit_scalar();
        else if (k == 9) put({14'd0, 3'(pick(8)), 3'b111, r[11:7], 7'h57}); // vsetivli
        else begin
            case (pick(4))
                0:       put({r[31:7], 7'h07});
                1:       put({r[31:7], 7'h27});
                2:       put({r[31:15], 3'b000, r[11:7], 7'h57});
                default: put({r[31:7], 7'h7f});
            endcase
        end
    endtask

    task automatic build_program();
        int          body;
        logic [4:0]  r;
        nwords = 0;
        put({14'd0, 3'(pick(8)), 3'b111, 5'd0, 7'h57});
        repeat (2 + pick(6)) emit_mix();
        r = src_reg();
        put(enc_b(13'd8, r, r)); // equal operands so it falls through
        emit_mix();
        put(enc_i(12'(1 + pick(4)), 5'd0, 3'b000, 5'd31, 7'h13));
        written[31] = 1'b1;
        body = nwords;
        repeat (2 + pick(5)) emit_mix();
        put(enc_i(12'hfff, 5'd31, 3'b000, 5'd31, 7'h13));
        put(enc_b(13'((body - nwords) * 4), 5'd31, 5'd0));
        repeat (2 + pick(6)) emit_mix();
        put(32'h1050_0073); // wfi
    endtask

    task automatic load_program();
        for (int i = 0; i < nwords; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = i[`VCORE_IMEM_AW-1:0];
            prog_data = prog[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    // vector engine stand-in that completes in issue order
    always @(posedge clk) begin
        if (!rst && vec_start) due_q.push_back(cyc + 1 + pick(6));
    end

    always @(negedge clk) begin
        if (rst) begin
            vec_done = 1'b0;
        end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
            vec_done = 1'b1;
            void'(due_q.pop_front());
        end else begin
            vec_done = 1'b0;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rng       = SEED;
        written   = 32'h1; // x0 only
        rst       = 1'b1;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        vec_done  = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk); // idle outputs are watched here
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = chk0.err_cnt;
            build_program();
            load_program();
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            @(posedge clk);
            while (ap_done !== 1'b1) @(posedge clk);
            repeat (12) @(negedge clk); // room for stray commands or a second ap_done
            $display("test %0d finished: %0d words, %0d new errors", t, nwords,
                     chk0.err_cnt - errs_before);
        end
        $display("totals: %0d tests, %0d checks, %0d ap_done, %0d errors", NUM_TESTS,
                 chk0.chk_cnt, chk0.done_cnt, chk0.err_cnt);
        if (chk0.err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/vcore_pkg.sv
common/decode_if.sv
isa_decoder/isa_decoder.sv
logic/fetch_unit.sv
logic/scalar_unit.sv
logic/vector_issue.sv
logic/vcore_top.sv
dv/vcore_checker.sv
dv/vcore_tb.sv

/* Bender.yml */
package:
  name: vcore

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/vcore_pkg.sv
      - common/decode_if.sv
      - isa_decoder/isa_decoder.sv
      - logic/fetch_unit.sv
      - logic/scalar_unit.sv
      - logic/vector_issue.sv
      - logic/vcore_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/vcore_checker.sv
      - dv/vcore_tb.sv
